/* source/tile_mem_pkg.sv */
// Tile memory path definitions

package tile_mem_pkg;

   // Bus geometry, window matches the board DRAM
   localparam int ADDR_WIDTH = 28;
   localparam int DATA_WIDTH = 32;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;

   // On-chip RAM standing in for DRAM
   localparam int MEM_WORDS   = 1024;
   localparam int IDX_WIDTH   = $clog2(MEM_WORDS);
   localparam int BYTE_OFFSET = $clog2(STRB_WIDTH);

   // Accesses with this bit set hit the unmapped hole
   localparam int UNMAPPED_BIT = 27;

   // Handshake watchdog
   localparam int TIMEOUT_CYCLES = 64;
   localparam int TIMER_WIDTH    = $clog2(TIMEOUT_CYCLES + 1);

   typedef logic [ADDR_WIDTH-1:0]  addr_t;
   typedef logic [DATA_WIDTH-1:0]  data_t;
   typedef logic [STRB_WIDTH-1:0]  strb_t;
   typedef logic [1:0]             resp_t;
   typedef logic [IDX_WIDTH-1:0]   mem_idx_t;
   typedef logic [TIMER_WIDTH-1:0] timer_t;

   localparam resp_t RESP_OKAY = 2'b00;

   // Wishbone classic, tile side
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      addr_t adr;
      data_t dat;
      strb_t sel;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      logic  err;
      data_t dat;
   } wb_rsp_t;

   // AXI channel payloads, valid and ready travel separately
   typedef struct packed {
      addr_t addr;
   } axi_aw_t;

   typedef struct packed {
      addr_t addr;
   } axi_ar_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } axi_w_t;

   typedef struct packed {
      resp_t resp;
   } axi_b_t;

   typedef struct packed {
      data_t data;
      resp_t resp;
      logic  last;
   } axi_r_t;

   typedef enum logic [2:0] {
      IDLE,
      WR_ADDR_DATA,
      WR_RESP,
      RD_ADDR,
      RD_DATA,
      DONE
   } bridge_state_e;

endpackage

/* source/wb2axi_ctrl.sv */
// Wishbone to AXI bridge control

`timescale 1ns/1ps

module wb2axi_ctrl (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic                aw_ready_i,
   input  logic                w_ready_i,
   input  logic                ar_ready_i,
   input  logic                b_valid_i,
   input  logic                r_valid_i,
   input  tile_mem_pkg::resp_t b_resp_i,
   input  tile_mem_pkg::resp_t r_resp_i,
   input  logic                expired_i,
   output logic                aw_valid_o,
   output logic                w_valid_o,
   output logic                ar_valid_o,
   output logic                b_ready_o,
   output logic                r_ready_o,
   output logic                load_o,
   output logic                capture_o,
   output logic                timer_start_o,
   output logic                timer_run_o,
   output logic                ack_o,
   output logic                err_o
);
   import tile_mem_pkg::*;

   bridge_state_e state_q, state_d;
   logic          aw_done_q, aw_done_d;
   logic          w_done_q, w_done_d;
   logic          err_q, err_d;
   logic          aw_fire, w_fire;

   // AW and W may complete in different cycles
   assign aw_fire = (state_q == WR_ADDR_DATA) && !aw_done_q && aw_ready_i;
   assign w_fire  = (state_q == WR_ADDR_DATA) && !w_done_q && w_ready_i;

   always_comb begin
      state_d       = state_q;
      aw_done_d     = aw_done_q;
      w_done_d      = w_done_q;
      err_d         = err_q;
      aw_valid_o    = 1'b0;
      w_valid_o     = 1'b0;
      ar_valid_o    = 1'b0;
      b_ready_o     = 1'b0;
      r_ready_o     = 1'b0;
      load_o        = 1'b0;
      capture_o     = 1'b0;
      timer_start_o = 1'b0;
      timer_run_o   = 1'b0;
      ack_o         = 1'b0;
      err_o         = 1'b0;

      unique case (state_q)
         IDLE: begin
            if (wb_cyc_i && wb_stb_i) begin
               load_o        = 1'b1;
               timer_start_o = 1'b1;
               aw_done_d     = 1'b0;
               w_done_d      = 1'b0;
               err_d         = 1'b0;
               state_d       = wb_we_i ? WR_ADDR_DATA : RD_ADDR;
            end
         end
         WR_ADDR_DATA: begin
            aw_valid_o  = !aw_done_q;
            w_valid_o   = !w_done_q;
            timer_run_o = 1'b1;
            aw_done_d   = aw_done_q | aw_fire;
            w_done_d    = w_done_q | w_fire;
            if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
               timer_start_o = 1'b1;
               state_d       = WR_RESP;
            end else if (expired_i) begin
               // Withdraw valids, the slave never answered
               err_d   = 1'b1;
               state_d = DONE;
            end
         end
         WR_RESP: begin
            b_ready_o   = 1'b1;
            timer_run_o = 1'b1;
            if (b_valid_i) begin
               err_d   = (b_resp_i != RESP_OKAY);
               state_d = DONE;
            end else if (expired_i) begin
               err_d   = 1'b1;
               state_d = DONE;
            end
         end
         RD_ADDR: begin
            ar_valid_o  = 1'b1;
            timer_run_o = 1'b1;
            if (ar_ready_i) begin
               timer_start_o = 1'b1;
               state_d       = RD_DATA;
            end else if (expired_i) begin
               err_d   = 1'b1;
               state_d = DONE;
            end
         end
         RD_DATA: begin
            r_ready_o   = 1'b1;
            timer_run_o = 1'b1;
            if (r_valid_i) begin
               capture_o = 1'b1;
               err_d     = (r_resp_i != RESP_OKAY);
               state_d   = DONE;
            end else if (expired_i) begin
               err_d   = 1'b1;
               state_d = DONE;
            end
         end
         DONE: begin
            // Single answer cycle, a held stb is not taken here
            ack_o   = !err_q;
            err_o   = err_q;
            state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= IDLE;
         aw_done_q <= 1'b0;
         w_done_q  <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         state_q   <= state_d;
         aw_done_q <= aw_done_d;
         w_done_q  <= w_done_d;
         err_q     <= err_d;
      end
   end

endmodule

/* source/wb2axi_watchdog.sv */
// Bridge handshake watchdog

`timescale 1ns/1ps

module wb2axi_watchdog (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic start_i,
   input  logic run_i,
   output logic expired_o
);
   import tile_mem_pkg::*;

   timer_t count_q;

   // Restart has priority over counting down
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (start_i) begin
         count_q <= timer_t'(TIMEOUT_CYCLES);
      end else if (run_i && (count_q != '0)) begin
         count_q <= count_q - 1'b1;
      end
   end

   // Only meaningful while the bridge is waiting
   assign expired_o = run_i && (count_q == '0);

endmodule

/* source/wb2axi_datapath.sv */
// Bridge request and read data registers

`timescale 1ns/1ps

module wb2axi_datapath (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  load_i,
   input  logic                  capture_i,
   input  tile_mem_pkg::addr_t   wb_adr_i,
   input  tile_mem_pkg::data_t   wb_dat_i,
   input  tile_mem_pkg::strb_t   wb_sel_i,
   input  tile_mem_pkg::data_t   r_data_i,
   output tile_mem_pkg::axi_aw_t aw_o,
   output tile_mem_pkg::axi_ar_t ar_o,
   output tile_mem_pkg::axi_w_t  w_o,
   output tile_mem_pkg::data_t   rd_data_o
);
   import tile_mem_pkg::*;

   addr_t addr_q;
   data_t wdata_q;
   strb_t strb_q;
   data_t rdata_q;

   // Request is held for the whole access
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         addr_q  <= '0;
         wdata_q <= '0;
         strb_q  <= '0;
      end else if (load_i) begin
         // Word aligned, byte lanes come from sel
         addr_q  <= {wb_adr_i[ADDR_WIDTH-1:BYTE_OFFSET], {BYTE_OFFSET{1'b0}}};
         wdata_q <= wb_dat_i;
         strb_q  <= wb_sel_i;
      end
   end

   // Read data stays stable through the ack cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
      end else if (capture_i) begin
         rdata_q <= r_data_i;
      end
   end

   assign aw_o.addr = addr_q;
   assign ar_o.addr = addr_q;

   // Every transfer is a single beat
   assign w_o.data = wdata_q;
   assign w_o.strb = strb_q;
   assign w_o.last = 1'b1;

   assign rd_data_o = rdata_q;

endmodule

/* source/axi_mem.sv */
// Single beat AXI memory

`timescale 1ns/1ps

module axi_mem (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  aw_valid_i,
   input  logic                  w_valid_i,
   input  logic                  ar_valid_i,
   input  logic                  b_ready_i,
   input  logic                  r_ready_i,
   input  tile_mem_pkg::axi_aw_t aw_i,
   input  tile_mem_pkg::axi_w_t  w_i,
   input  tile_mem_pkg::axi_ar_t ar_i,
   output logic                  aw_ready_o,
   output logic                  w_ready_o,
   output logic                  ar_ready_o,
   output logic                  b_valid_o,
   output logic                  r_valid_o,
   output tile_mem_pkg::axi_b_t  b_o,
   output tile_mem_pkg::axi_r_t  r_o
);
   import tile_mem_pkg::*;

   data_t    mem_q [MEM_WORDS];
   data_t    r_data_q;
   logic     wr_ready_q;
   logic     rd_ready_q;
   logic     b_valid_q;
   logic     r_valid_q;
   logic     wr_mapped, rd_mapped;
   logic     wr_fire, rd_fire;
   mem_idx_t wr_idx, rd_idx;

   // Upper half is a hole, it never gets a ready
   assign wr_mapped = !aw_i.addr[UNMAPPED_BIT];
   assign rd_mapped = !ar_i.addr[UNMAPPED_BIT];

   // Word index, the mapped region wraps every 4 KiB
   assign wr_idx = aw_i.addr[BYTE_OFFSET +: IDX_WIDTH];
   assign rd_idx = ar_i.addr[BYTE_OFFSET +: IDX_WIDTH];

   assign wr_fire = wr_ready_q && aw_valid_i && w_valid_i;
   assign rd_fire = rd_ready_q && ar_valid_i;

   // Write channel, AW and W accepted together
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ready_q <= 1'b0;
         b_valid_q  <= 1'b0;
      end else begin
         wr_ready_q <= aw_valid_i && w_valid_i && wr_mapped
                       && !wr_ready_q && !b_valid_q;
         if (wr_fire) begin
            b_valid_q <= 1'b1;
         end else if (b_ready_i) begin
            b_valid_q <= 1'b0;
         end
      end
   end

   // Read channel
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ready_q <= 1'b0;
         r_valid_q  <= 1'b0;
      end else begin
         rd_ready_q <= ar_valid_i && rd_mapped && !rd_ready_q && !r_valid_q;
         if (rd_fire) begin
            r_valid_q <= 1'b1;
         end else if (r_ready_i) begin
            r_valid_q <= 1'b0;
         end
      end
   end

   // Storage, byte lanes under strobe
   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         for (int i = 0; i < STRB_WIDTH; i++) begin
            if (w_i.strb[i]) begin
               mem_q[wr_idx][8*i +: 8] <= w_i.data[8*i +: 8];
            end
         end
      end
      if (rd_fire) begin
         r_data_q <= mem_q[rd_idx];
      end
   end

   assign aw_ready_o = wr_ready_q;
   assign w_ready_o  = wr_ready_q;
   assign ar_ready_o = rd_ready_q;
   assign b_valid_o  = b_valid_q;
   assign r_valid_o  = r_valid_q;

   // Mapped accesses always succeed
   assign b_o.resp = RESP_OKAY;
   assign r_o.data = r_data_q;
   assign r_o.resp = RESP_OKAY;
   assign r_o.last = 1'b1;

endmodule

/* source/tile_mem_top.sv */
// Tile memory path top level

`timescale 1ns/1ps

module tile_mem_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  tile_mem_pkg::wb_req_t wb_req_i,
   output tile_mem_pkg::wb_rsp_t wb_rsp_o
);
   import tile_mem_pkg::*;

   // AXI handshakes between bridge and memory
   logic    aw_valid, aw_ready;
   logic    w_valid, w_ready;
   logic    ar_valid, ar_ready;
   logic    b_valid, b_ready;
   logic    r_valid, r_ready;
   axi_aw_t aw;
   axi_w_t  w;
   axi_ar_t ar;
   axi_b_t  b;
   axi_r_t  r;

   // Bridge internals
   logic    load, capture;
   logic    timer_start, timer_run, expired;
   logic    ack, err;
   data_t   rd_data;

   wb2axi_ctrl u_ctrl (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .wb_cyc_i      (wb_req_i.cyc),
      .wb_stb_i      (wb_req_i.stb),
      .wb_we_i       (wb_req_i.we),
      .aw_ready_i    (aw_ready),
      .w_ready_i     (w_ready),
      .ar_ready_i    (ar_ready),
      .b_valid_i     (b_valid),
      .r_valid_i     (r_valid),
      .b_resp_i      (b.resp),
      .r_resp_i      (r.resp),
      .expired_i     (expired),
      .aw_valid_o    (aw_valid),
      .w_valid_o     (w_valid),
      .ar_valid_o    (ar_valid),
      .b_ready_o     (b_ready),
      .r_ready_o     (r_ready),
      .load_o        (load),
      .capture_o     (capture),
      .timer_start_o (timer_start),
      .timer_run_o   (timer_run),
      .ack_o         (ack),
      .err_o         (err)
   );

   wb2axi_watchdog u_watchdog (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .start_i   (timer_start),
      .run_i     (timer_run),
      .expired_o (expired)
   );

   wb2axi_datapath u_datapath (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .load_i    (load),
      .capture_i (capture),
      .wb_adr_i  (wb_req_i.adr),
      .wb_dat_i  (wb_req_i.dat),
      .wb_sel_i  (wb_req_i.sel),
      .r_data_i  (r.data),
      .aw_o      (aw),
      .ar_o      (ar),
      .w_o       (w),
      .rd_data_o (rd_data)
   );

   // Stands in for the board DRAM controller
   axi_mem u_mem (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .aw_valid_i (aw_valid),
      .w_valid_i  (w_valid),
      .ar_valid_i (ar_valid),
      .b_ready_i  (b_ready),
      .r_ready_i  (r_ready),
      .aw_i       (aw),
      .w_i        (w),
      .ar_i       (ar),
      .aw_ready_o (aw_ready),
      .w_ready_o  (w_ready),
      .ar_ready_o (ar_ready),
      .b_valid_o  (b_valid),
      .r_valid_o  (r_valid),
      .b_o        (b),
      .r_o        (r)
   );

   assign wb_rsp_o.ack = ack;
   assign wb_rsp_o.err = err;
   assign wb_rsp_o.dat = rd_data;

endmodule

/* sim/tb_tile_mem_top.sv */
// Tile memory path testbench

`timescale 1ns/1ps

module tb_tile_mem_top;
   import tile_mem_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int ACCESS_LIMIT = TIMEOUT_CYCLES + 16;
   localparam int RUN_LIMIT_NS = 100 * ACCESS_LIMIT * CLK_PERIOD;
   // Words used by the tests, placed just below the 4 KiB wrap
   localparam mem_idx_t POOL_BASE = 10'h3f0;

   typedef struct packed {
      logic  is_read;
      logic  exp_err;
      data_t exp_dat;
   } expect_t;

   logic    clk;
   logic    rst_n;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   data_t       model_mem [MEM_WORDS];
   expect_t     expect_q[$];
   logic [31:0] rng;
   int          errors;
   int          checks;
   int          errs_before;

   tile_mem_top u_tile_mem_top (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Whole run limit
   initial begin
      #(RUN_LIMIT_NS);
      $display("The run timed out after %0d ns without finishing the tests", RUN_LIMIT_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Word index with the 4 KiB wrap of the mapped region
   function automatic mem_idx_t word_index(input addr_t adr);
      return mem_idx_t'((adr % 4096) / 4);
   endfunction

   function automatic data_t ref_read(input addr_t adr);
      return model_mem[word_index(adr)];
   endfunction

   function automatic void ref_write(input addr_t adr, input data_t dat, input strb_t sel);
      data_t mask;
      data_t old;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      old  = model_mem[word_index(adr)];
      model_mem[word_index(adr)] = (old & ~mask) | (dat & mask);
   endfunction

   // One Wishbone classic access, ends when ack or err is seen
   task automatic wb_access(input logic we, input addr_t adr, input data_t dat,
                            input strb_t sel, output logic got_ack, output logic got_err,
                            output data_t got_dat);
      int   waited;
      logic seen;
      waited  = 0;
      seen    = 1'b0;
      got_ack = 1'b0;
      got_err = 1'b0;
      got_dat = '0;
      @(posedge clk);
      #1;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      wb_req.sel = sel;
      while (!seen && waited < ACCESS_LIMIT) begin
         @(negedge clk);
         waited++;
         if (wb_rsp.ack || wb_rsp.err) begin
            seen    = 1'b1;
            got_ack = wb_rsp.ack;
            got_err = wb_rsp.err;
            got_dat = wb_rsp.dat;
         end
      end
      if (!seen) begin
         $display("Access to address %h got neither ack nor err within %0d cycles",
                  adr, ACCESS_LIMIT);
         errors++;
         expect_q.delete();
      end
      @(posedge clk);
      #1;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
   endtask

   task automatic write_word(input addr_t adr, input data_t dat, input strb_t sel,
                             input logic exp_err);
      logic  ack;
      logic  err;
      data_t rdat;
      expect_q.push_back('{is_read: 1'b0, exp_err: exp_err, exp_dat: '0});
      wb_access(1'b1, adr, dat, sel, ack, err, rdat);
      // A failed write must leave memory untouched
      if (!exp_err) begin
         ref_write(adr, dat, sel);
      end
   endtask

   task automatic read_word(input addr_t adr, input logic exp_err);
      logic  ack;
      logic  err;
      data_t rdat;
      expect_q.push_back('{is_read: 1'b1, exp_err: exp_err, exp_dat: ref_read(adr)});
      wb_access(1'b0, adr, '0, '0, ack, err, rdat);
   endtask

   task automatic report_test(input int num, input string name);
      if (errors == errs_before) begin
         $display("Test %0d %s: passed", num, name);
      end else begin
         $display("Test %0d %s: failed with %0d errors", num, name, errors - errs_before);
      end
      errs_before = errors;
   endtask

   // Checks every answer against the expected entry
   always @(negedge clk) begin : compare_answers
      expect_t e;
      if (rst_n && (wb_rsp.ack || wb_rsp.err)) begin
         if (wb_rsp.ack && wb_rsp.err) begin
            $display("[FAIL] %0t: ack and err raised together", $time);
            errors++;
         end
         if (expect_q.size() == 0) begin
            $display("An answer arrived at %0t with no request outstanding", $time);
            errors++;
         end else begin
            e = expect_q.pop_front();
            checks++;
            if (e.exp_err && !wb_rsp.err) begin
               $display("[FAIL] %0t: expected err, got ack", $time);
               errors++;
            end
            if (!e.exp_err && !wb_rsp.ack) begin
               $display("[FAIL] %0t: expected ack, got err", $time);
               errors++;
            end
            if (!e.exp_err && e.is_read && (wb_rsp.dat !== e.exp_dat)) begin
               $display("[FAIL] %0t: read data %h, expected %h", $time, wb_rsp.dat, e.exp_dat);
               errors++;
            end
         end
      end
   end

   initial begin
      addr_t    adr;
      mem_idx_t idx;
      strb_t    part_sel [4];
      wb_req      = '0;
      rst_n       = 1'b0;
      rng         = 32'hab57;
      errors      = 0;
      checks      = 0;
      errs_before = 0;
      part_sel    = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Quiet bus after reset
      repeat (8) begin
         @(negedge clk);
         checks++;
         if (wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0) begin
            $display("[FAIL] %0t: ack or err not low while idle", $time);
            errors++;
         end
      end
      report_test(1, "idle after reset");

      for (int k = 0; k < 16; k++) begin
         rng = lcg_next(rng);
         write_word({1'b0, 15'h0, POOL_BASE + mem_idx_t'(k), 2'b00}, rng, 4'hf, 1'b0);
      end
      for (int k = 0; k < 16; k++) begin
         read_word({1'b0, 15'h0, POOL_BASE + mem_idx_t'(k), 2'b00}, 1'b0);
      end
      report_test(2, "full word write and read");

      for (int k = 0; k < 4; k++) begin
         rng = lcg_next(rng);
         write_word({1'b0, 15'h0, POOL_BASE + mem_idx_t'(k), 2'b00}, rng, part_sel[k], 1'b0);
         read_word({1'b0, 15'h0, POOL_BASE + mem_idx_t'(k), 2'b00}, 1'b0);
      end
      report_test(3, "partial byte select");

      // Random upper bits alias onto the same pool words
      for (int k = 0; k < 64; k++) begin
         rng = lcg_next(rng);
         idx = POOL_BASE + mem_idx_t'(rng[3:0]);
         adr = {1'b0, rng[26:12], idx, rng[5:4]};
         if (rng[31]) begin
            rng = lcg_next(rng);
            write_word(adr, rng, rng[11:8], 1'b0);
         end else begin
            read_word(adr, 1'b0);
         end
      end
      report_test(4, "random access");

      read_word({1'b1, 15'h0, POOL_BASE, 2'b00}, 1'b1);
      write_word({1'b1, 15'h0, POOL_BASE, 2'b00}, 32'hdead_beef, 4'hf, 1'b1);
      read_word({1'b0, 15'h0, POOL_BASE, 2'b00}, 1'b0);
      write_word({1'b0, 15'h1, POOL_BASE + 10'd1, 2'b00}, 32'h1234_5678, 4'hf, 1'b0);
      read_word({1'b0, 15'h0, POOL_BASE + 10'd1, 2'b00}, 1'b0);
      report_test(5, "unmapped region");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* project.f */
source/tile_mem_pkg.sv
source/wb2axi_ctrl.sv
source/wb2axi_watchdog.sv
source/wb2axi_datapath.sv
source/axi_mem.sv
source/tile_mem_top.sv
sim/tb_tile_mem_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_tile_mem_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
